// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_lcd_top
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
SRCS      = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/lcd_byte_sender.sv ====
module lcd_byte_sender #(
    parameter int TICKS_TAS   = 3,
    parameter int TICKS_PWEH  = 22,
    parameter int TICKS_TCYCE = 48
) (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_stb,
    input  logic                      i_rs,
    input  logic [7:0]                i_byte,
    output logic                      o_busy,
    output logic                      o_lcd_rs,
    output logic                      o_lcd_e,
    output logic [lcd_pkg::NYB_W-1:0] o_lcd_data
);
    import lcd_pkg::*;

    // one strobe state per nybble, each followed by a wait
    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_HI      = 3'd1;   // high nybble strobe
    localparam logic [2:0] S_HI_WAIT = 3'd2;
    localparam logic [2:0] S_LO      = 3'd3;   // low nybble strobe
    localparam logic [2:0] S_LO_WAIT = 3'd4;

    logic [2:0]       state;
    logic [7:0]       byte_q;                  // held for both halves
    logic             rs_q;
    logic             nyb_stb;
    logic [NYB_W-1:0] nyb;
    logic             nyb_busy;

    assign o_busy  = (state != S_IDLE);        // up the cycle after i_stb
    assign nyb_stb = (state == S_HI) || (state == S_LO);
    assign nyb     = (state == S_HI) ? byte_q[2*NYB_W-1:NYB_W] : byte_q[NYB_W-1:0];

    // **************************************************
    // nybble sequencing
    // **************************************************
    // strobe states last one cycle, nyb_busy is still low there,
    // so the wait states only see the sender's own busy
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (i_stb) state <= S_HI;
                S_HI:      state <= S_HI_WAIT;
                S_HI_WAIT: if (!nyb_busy) state <= S_LO;
                S_LO:      state <= S_LO_WAIT;
                S_LO_WAIT: if (!nyb_busy) state <= S_IDLE;   // busy drops one later
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_stb) begin
            byte_q <= i_byte;
            rs_q   <= i_rs;
        end
    end

    lcd_nybble_sender #(
        .TICKS_TAS  (TICKS_TAS),
        .TICKS_PWEH (TICKS_PWEH),
        .TICKS_TCYCE(TICKS_TCYCE)
    ) nyb_i (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_stb     (nyb_stb),
        .i_rs      (rs_q),
        .i_nyb     (nyb),
        .o_busy    (nyb_busy),
        .o_lcd_rs  (o_lcd_rs),
        .o_lcd_e   (o_lcd_e),
        .o_lcd_data(o_lcd_data)
    );

endmodule

// ==== rtl/lcd_nybble_sender.sv ====
module lcd_nybble_sender #(
    parameter int TICKS_TAS   = 3,      // rs/data setup before e rises
    parameter int TICKS_PWEH  = 22,     // e high width
    parameter int TICKS_TCYCE = 48      // whole enable cycle
) (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_stb,
    input  logic                      i_rs,
    input  logic [lcd_pkg::NYB_W-1:0] i_nyb,
    output logic                      o_busy,
    output logic                      o_lcd_rs,
    output logic                      o_lcd_e,
    output logic [lcd_pkg::NYB_W-1:0] o_lcd_data
);

    // counter only ever reaches TICKS_TCYCE
    localparam int CNT_W = $clog2(TICKS_TCYCE + 1);

    logic [CNT_W-1:0] cnt;              // cycles since the strobe
    logic [CNT_W-1:0] cnt_nxt;
    logic             e_win;            // next cycle lies inside the e pulse
    logic             cyc_done;         // next cycle is past tcyce

    // **************************************************
    // timing windows
    // **************************************************
    // strobe cycle counts as 0, busy goes up in cycle 1
    // e high for cycles [TAS, TAS+PWEH), busy low again at cycle TCYCE
    assign cnt_nxt  = cnt + 1'b1;
    assign e_win    = (cnt_nxt >= TICKS_TAS) && (cnt_nxt < TICKS_TAS + TICKS_PWEH);
    assign cyc_done = (cnt_nxt >= TICKS_TCYCE);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt     <= '0;
            o_busy  <= 1'b0;
            o_lcd_e <= 1'b0;
        end else if (i_stb || o_busy) begin
            // cnt sits at 0 while idle, so a strobe starts from a clean count
            if (cyc_done) begin
                cnt    <= '0;
                o_busy <= 1'b0;
            end else begin
                cnt    <= cnt_nxt;
                o_busy <= 1'b1;
            end
            o_lcd_e <= e_win && !cyc_done;  // never leave e high past the cycle
        end
    end

    // **************************************************
    // pin payload
    // **************************************************
    // rs and data loaded with the strobe and held the whole cycle,
    // well clear of e on both sides
    always_ff @(posedge clk) begin
        if (i_stb) begin
            o_lcd_rs   <= i_rs;
            o_lcd_data <= i_nyb;
        end
    end

endmodule

// ==== rtl/lcd_pkg.sv ====
package lcd_pkg;

    // **************************************************
    // widths
    // **************************************************
    localparam int ADDR_W  = 8;                 // 256 word program ram
    localparam int WORD_W  = 16;                // one control word
    localparam int NYB_W   = 4;                 // lcd runs in 4-bit mode
    localparam int COUNT_W = WORD_W - 2;        // delay count, everything below the opcode

    // **************************************************
    // control word layout
    // **************************************************

    // opcode sits in the top two bits of every word
    typedef enum logic [1:0] {
        OP_END   = 2'b00,                       // stop, drop busy
        OP_SEND  = 2'b01,                       // byte out to the lcd
        OP_DELAY = 2'b10,                       // wait count * delay unit
        OP_BAD   = 2'b11                        // illegal, sets sticky error
    } op_e;

    // send view: op | 5 spare | rs | data byte
    typedef struct packed {
        op_e        op;
        logic [4:0] unused;                     // reserved, write as zero
        logic       rs;                         // 0 = command, 1 = data
        logic [7:0] data;
    } send_word_t;

    // delay view: op | count
    typedef struct packed {
        op_e                op;
        logic [COUNT_W-1:0] count;              // units of DELAY_UNIT clocks
    } delay_word_t;

    // same 16 bits, read either way depending on op
    typedef union packed {
        send_word_t  send;
        delay_word_t delay;
    } ctrl_word_u;

endpackage

// ==== rtl/lcd_ram.sv ====
module lcd_ram (
    input  logic                       clk,
    input  logic                       i_wr_en,
    input  logic [lcd_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [lcd_pkg::WORD_W-1:0] i_wr_data,
    input  logic [lcd_pkg::ADDR_W-1:0] i_rd_addr,
    output logic [lcd_pkg::WORD_W-1:0] o_rd_data
);
    import lcd_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    // plain array so the tools map it onto block ram
    logic [WORD_W-1:0] mem [0:DEPTH-1];

    // write side, loaded from outside
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read side, one cycle latency
    // same-address write shows up a cycle later, read gets old word
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== rtl/lcd_sequencer.sv ====
module lcd_sequencer #(
    parameter int DELAY_UNIT  = 16,     // clocks per delay count
    parameter int TICKS_TAS   = 3,
    parameter int TICKS_PWEH  = 22,
    parameter int TICKS_TCYCE = 48
) (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  logic                       i_start,
    input  logic [lcd_pkg::ADDR_W-1:0] i_start_addr,
    output logic [lcd_pkg::ADDR_W-1:0] o_rd_addr,
    input  lcd_pkg::ctrl_word_u        i_rd_data,
    output logic                       o_busy,
    output logic                       o_error,
    output logic                       o_lcd_rs,
    output logic                       o_lcd_e,
    output logic [lcd_pkg::NYB_W-1:0]  o_lcd_data
);
    import lcd_pkg::*;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_FETCH  = 3'd1;    // address out to ram
    localparam logic [2:0] S_WAIT   = 3'd2;    // ram word arrives, captured
    localparam logic [2:0] S_DECODE = 3'd3;
    localparam logic [2:0] S_SEND   = 3'd4;
    localparam logic [2:0] S_DELAY  = 3'd5;

    localparam int PRE_W = $clog2(DELAY_UNIT + 1);

    logic [2:0]         state;
    logic [ADDR_W-1:0]  addr;                  // current program counter
    ctrl_word_u         word_q;                // fetched word, both views
    logic [COUNT_W-1:0] dly_cnt;               // delay units left
    logic [PRE_W-1:0]   pre_cnt;               // clocks within one unit
    logic               pre_wrap;
    logic               byte_stb;
    logic               byte_busy;

    assign o_rd_addr = addr;
    assign o_busy    = (state != S_IDLE);
    assign pre_wrap  = (pre_cnt == PRE_W'(DELAY_UNIT - 1));

    // word stays put through send and delay, the byte sender
    // takes rs and data straight from it
    always_ff @(posedge clk) begin
        if (state == S_WAIT) begin
            word_q <= i_rd_data;
        end
    end

    // **************************************************
    // fetch / decode / execute
    // **************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= S_IDLE;
            addr     <= '0;
            dly_cnt  <= '0;
            pre_cnt  <= '0;
            byte_stb <= 1'b0;
            o_error  <= 1'b0;                  // sticky, only reset clears it
        end else begin
            byte_stb <= 1'b0;                  // one-cycle strobe
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        addr  <= i_start_addr;
                        state <= S_FETCH;
                    end
                end
                S_FETCH:  state <= S_WAIT;
                S_WAIT:   state <= S_DECODE;
                S_DECODE: begin
                    case (word_q.send.op)
                        OP_SEND: begin
                            byte_stb <= 1'b1;  // byte sender is idle here
                            state    <= S_SEND;
                        end
                        OP_DELAY: begin
                            dly_cnt <= word_q.delay.count;
                            pre_cnt <= '0;
                            if (word_q.delay.count == '0) begin
                                addr  <= addr + 1'b1;  // zero count, just move on
                                state <= S_FETCH;
                            end else begin
                                state <= S_DELAY;
                            end
                        end
                        OP_END:  state <= S_IDLE;
                        default: begin
                            o_error <= 1'b1;   // bad word ends the run
                            state   <= S_IDLE;
                        end
                    endcase
                end
                S_SEND: begin
                    // byte_busy only rises a cycle after the strobe
                    if (!byte_stb && !byte_busy) begin
                        addr  <= addr + 1'b1;  // wraps at 255
                        state <= S_FETCH;
                    end
                end
                S_DELAY: begin
                    if (pre_wrap) begin
                        pre_cnt <= '0;
                        if (dly_cnt == COUNT_W'(1)) begin
                            addr  <= addr + 1'b1;
                            state <= S_FETCH;
                        end else begin
                            dly_cnt <= dly_cnt - 1'b1;
                        end
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    lcd_byte_sender #(
        .TICKS_TAS  (TICKS_TAS),
        .TICKS_PWEH (TICKS_PWEH),
        .TICKS_TCYCE(TICKS_TCYCE)
    ) byte_i (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_stb     (byte_stb),
        .i_rs      (word_q.send.rs),
        .i_byte    (word_q.send.data),
        .o_busy    (byte_busy),
        .o_lcd_rs  (o_lcd_rs),
        .o_lcd_e   (o_lcd_e),
        .o_lcd_data(o_lcd_data)
    );

endmodule

// ==== rtl/lcd_top.sv ====
module lcd_top #(
    parameter int TICKS_TAS   = 3,
    parameter int TICKS_PWEH  = 22,
    parameter int TICKS_TCYCE = 48,
    parameter int DELAY_UNIT  = 16
) (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  logic                       i_button,       // active low
    input  logic                       i_wr_en,
    input  logic [lcd_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [lcd_pkg::WORD_W-1:0] i_wr_data,
    input  logic [lcd_pkg::ADDR_W-1:0] i_start_addr,
    output logic                       o_lcd_rs,
    output logic                       o_lcd_e,
    output logic [lcd_pkg::NYB_W-1:0]  o_lcd_data,
    output logic                       o_la_strobe,    // logic analyser trigger
    output logic                       o_busy,
    output logic                       o_error
);
    import lcd_pkg::*;

    logic              btn_meta;
    logic              btn_sync;
    logic              pressed;                // set once, held till reset
    logic              start_stb;
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] rd_data;

    // **************************************************
    // button: sync, latch, start pulse
    // **************************************************
    // sync flops idle high, matching a released button
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            btn_meta  <= 1'b1;
            btn_sync  <= 1'b1;
            pressed   <= 1'b0;
            start_stb <= 1'b0;
        end else begin
            btn_meta  <= i_button;
            btn_sync  <= btn_meta;
            start_stb <= !pressed && !btn_sync;   // only on the latch's rising edge
            if (!btn_sync) begin
                pressed <= 1'b1;                  // no debounce needed, first low wins
            end
        end
    end

    assign o_la_strobe = pressed;

    lcd_ram ram_i (
        .clk      (clk),
        .i_wr_en  (i_wr_en),
        .i_wr_addr(i_wr_addr),
        .i_wr_data(i_wr_data),
        .i_rd_addr(rd_addr),
        .o_rd_data(rd_data)
    );

    lcd_sequencer #(
        .DELAY_UNIT (DELAY_UNIT),
        .TICKS_TAS  (TICKS_TAS),
        .TICKS_PWEH (TICKS_PWEH),
        .TICKS_TCYCE(TICKS_TCYCE)
    ) seq_i (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_start     (start_stb),
        .i_start_addr(i_start_addr),
        .o_rd_addr   (rd_addr),
        .i_rd_data   (rd_data),                  // raw word into the union port
        .o_busy      (o_busy),
        .o_error     (o_error),
        .o_lcd_rs    (o_lcd_rs),
        .o_lcd_e     (o_lcd_e),
        .o_lcd_data  (o_lcd_data)
    );

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    input  logic i_rst_req,                 // rising edge starts another reset
    output logic clk,
    output logic o_arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset first, then one more for every request
    initial begin
        o_arst_n = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1 o_arst_n = 1'b1;             // release just clear of the edge
            @(posedge i_rst_req);
            #1 o_arst_n = 1'b0;
        end
    end

endmodule

// ==== tb/tb_lcd_top.sv ====
module tb_lcd_top;
    import lcd_pkg::*;

    localparam int TICKS_TAS   = 3;
    localparam int TICKS_PWEH  = 22;
    localparam int TICKS_TCYCE = 48;
    localparam int DELAY_UNIT  = 16;
    localparam int DRIVE_DLY   = 2;         // inputs change this long after posedge
    localparam int MAX_PULSES  = 512;       // two per word over the whole ram
    localparam int MARGIN      = 200;       // cycles on top of every budget
    localparam int IDLE_CYC    = 40;
    localparam int DLY_COUNT   = 5;         // count used in the delay test

    logic              clk;
    logic              arst_n;
    logic              rst_req;
    logic              i_button;
    logic              i_wr_en;
    logic [ADDR_W-1:0] i_wr_addr;
    logic [WORD_W-1:0] i_wr_data;
    logic [ADDR_W-1:0] i_start_addr;
    logic              o_lcd_rs;
    logic              o_lcd_e;
    logic [NYB_W-1:0]  o_lcd_data;
    logic              o_la_strobe;
    logic              o_busy;
    logic              o_error;

    logic [WORD_W-1:0] prog [0:255];        // copy of what went into the ram
    int                seed = 32'hbd8c9663;

    // expected pulses from the reference function
    logic              exp_rs  [0:MAX_PULSES-1];
    logic [NYB_W-1:0]  exp_nyb [0:MAX_PULSES-1];
    int                exp_n = 0;
    logic              exp_err;
    int                exp_dly;             // sum of delay counts on the path
    int                exp_words;

    // monitor state owned by the compare process
    int                pulse_cnt = 0;
    int                width;
    logic              e_prev;
    logic              cur_rs;
    logic [NYB_W-1:0]  cur_nyb;
    int                rise_cyc [0:MAX_PULSES-1];
    int                fall_cyc [0:MAX_PULSES-1];

    int                cyc_now   = 0;       // free running cycle count
    int                run_base  = 0;
    int                run_limit = 100;     // covers the power-on reset

    tb_clock #(
        .PERIOD      (20),
        .RESET_CYCLES(8)
    ) clk_i (
        .i_rst_req(rst_req),
        .clk      (clk),
        .o_arst_n (arst_n)
    );

    lcd_top #(
        .TICKS_TAS  (TICKS_TAS),
        .TICKS_PWEH (TICKS_PWEH),
        .TICKS_TCYCE(TICKS_TCYCE),
        .DELAY_UNIT (DELAY_UNIT)
    ) dut_i (
        .clk         (clk),
        .i_arst_n    (arst_n),
        .i_button    (i_button),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_start_addr(i_start_addr),
        .o_lcd_rs    (o_lcd_rs),
        .o_lcd_e     (o_lcd_e),
        .o_lcd_data  (o_lcd_data),
        .o_la_strobe (o_la_strobe),
        .o_busy      (o_busy),
        .o_error     (o_error)
    );

    // **************************************************
    // failure reporting
    // **************************************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    // **************************************************
    // word encoding and reference model
    // **************************************************
    function automatic logic [WORD_W-1:0] make_send(input logic rs, input logic [7:0] data);
        ctrl_word_u w;
        w           = '0;                   // spare bits stay zero
        w.send.op   = OP_SEND;
        w.send.rs   = rs;
        w.send.data = data;
        return w;
    endfunction

    function automatic logic [WORD_W-1:0] make_delay(input logic [COUNT_W-1:0] count);
        ctrl_word_u w;
        w             = '0;
        w.delay.op    = OP_DELAY;
        w.delay.count = count;
        return w;
    endfunction

    function automatic logic [WORD_W-1:0] make_op(input op_e op);
        ctrl_word_u w;
        w         = '0;
        w.send.op = op;                     // END or BAD with no payload
        return w;
    endfunction

    // walk the program as the LCD should see it with the high nybble of each send first
    function automatic void build_expected(input logic [ADDR_W-1:0] start);
        ctrl_word_u        w;
        logic [ADDR_W-1:0] a;
        bit                stop;
        int                i;
        a         = start;
        stop      = 1'b0;
        exp_n     = 0;
        exp_err   = 1'b0;
        exp_dly   = 0;
        exp_words = 0;
        for (i = 0; i < 256 && !stop; i++) begin
            w = prog[a];
            exp_words++;
            case (w.send.op)
                OP_SEND: begin
                    exp_rs[exp_n]      = w.send.rs;
                    exp_nyb[exp_n]     = w.send.data[7:4];
                    exp_rs[exp_n + 1]  = w.send.rs;
                    exp_nyb[exp_n + 1] = w.send.data[3:0];
                    exp_n += 2;
                end
                OP_DELAY: exp_dly += int'(w.delay.count);
                OP_END:   stop = 1'b1;
                default: begin
                    exp_err = 1'b1;         // nothing after a bad word
                    stop    = 1'b1;
                end
            endcase
            a = a + 1'b1;                   // 8-bit address wraps like the DUT
        end
    endfunction

    // **************************************************
    // compare process on every falling clock
    // **************************************************
    always @(negedge clk) begin
        if (!arst_n) begin
            pulse_cnt = 0;                  // every test starts from a reset
            e_prev    = 1'b0;
            width     = 0;
        end else begin
            if (o_lcd_e && !e_prev) begin
                if (pulse_cnt >= exp_n) begin
                    abort_run($sformatf("unexpected E pulse at %0t, only %0d expected",
                                        $time, exp_n));
                end else begin
                    check(o_lcd_rs, exp_rs[pulse_cnt], "rs at E rise");
                    check(o_lcd_data, exp_nyb[pulse_cnt], "nybble at E rise");
                    cur_rs              = o_lcd_rs;
                    cur_nyb             = o_lcd_data;
                    width               = 1;
                    rise_cyc[pulse_cnt] = cyc_now;
                    pulse_cnt++;
                end
            end else if (o_lcd_e) begin
                width++;
                check(o_lcd_rs, cur_rs, "rs moved while E high");
                check(o_lcd_data, cur_nyb, "data moved while E high");
            end else if (e_prev) begin
                check(width, TICKS_PWEH, "E pulse width");
                fall_cyc[pulse_cnt - 1] = cyc_now;
            end
            e_prev = o_lcd_e;
        end
    end

    // watchdog with a budget per phase
    always @(posedge clk) begin
        cyc_now = cyc_now + 1;
        if (cyc_now - run_base > run_limit) begin
            abort_run($sformatf("timeout: run stuck for more than %0d cycles", run_limit));
        end
    end

    task automatic start_timer(input int limit);
        run_base  = cyc_now;
        run_limit = limit;
    endtask

    // **************************************************
    // stimulus tasks
    // **************************************************
    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        i_wr_en    = 1'b1;
        i_wr_addr  = addr;
        i_wr_data  = data;
        prog[addr] = data;
    endtask

    task automatic end_writes;
        @(posedge clk);
        #DRIVE_DLY;
        i_wr_en = 1'b0;
    endtask

    task automatic write_random_send(input logic [ADDR_W-1:0] addr);
        logic [7:0] data;
        logic       rs;
        data = 8'($random(seed));
        rs   = 1'($random(seed));
        write_word(addr, make_send(rs, data));
    endtask

    // reset also releases the button and everything must read low
    task automatic apply_reset;
        start_timer(MARGIN);
        @(posedge clk);
        #DRIVE_DLY;
        i_button = 1'b1;
        rst_req  = 1'b1;
        wait (arst_n === 1'b0);
        rst_req = 1'b0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        check(o_la_strobe, 1'b0, "strobe after reset");
        check(o_busy, 1'b0, "busy after reset");
        check(o_error, 1'b0, "error after reset");
        check(o_lcd_e, 1'b0, "E after reset");
    endtask

    task automatic run_program(input logic [ADDR_W-1:0] start);
        build_expected(start);
        start_timer(exp_n * TICKS_TCYCE * 2 + exp_dly * DELAY_UNIT + exp_words * 8 + MARGIN);
        @(posedge clk);
        #DRIVE_DLY;
        i_start_addr = start;
        i_button     = 1'b0;                // press held until the next reset
        wait (o_busy === 1'b1);
        check(o_la_strobe, 1'b1, "strobe once running");
        wait (o_busy === 1'b0);
        repeat (TICKS_TCYCE) @(posedge clk);  // room for a stray pulse to show
        check(pulse_cnt, exp_n, "E pulse count");
        check(o_error, exp_err, "error flag at end");
        check(o_la_strobe, 1'b1, "strobe after run");
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        i_button     = 1'b1;
        i_wr_en      = 1'b0;
        i_wr_addr    = '0;
        i_wr_data    = '0;
        i_start_addr = '0;
        rst_req      = 1'b0;
        wait (arst_n === 1'b1);

        // idle without a press
        start_timer(IDLE_CYC + MARGIN);
        repeat (IDLE_CYC) begin
            @(negedge clk);
            check(o_lcd_e, 1'b0, "E while idle");
            check(o_busy, 1'b0, "busy while idle");
            check(o_error, 1'b0, "error while idle");
            check(o_la_strobe, 1'b0, "strobe before press");
        end

        // random bytes from address 0
        start_timer(MARGIN);
        for (int a = 0; a < 8; a++) begin
            write_random_send(ADDR_W'(a));
        end
        write_word(8, make_op(OP_END));
        end_writes();
        run_program(0);

        // delay between two sends
        apply_reset();
        write_random_send(16);
        write_word(17, make_delay(DLY_COUNT));
        write_random_send(18);
        write_word(19, make_op(OP_END));
        end_writes();
        run_program(16);
        check((rise_cyc[2] - fall_cyc[1]) >= DLY_COUNT * DELAY_UNIT, 1'b1,
              "gap across delay word");

        // bad word cuts the program short
        apply_reset();
        write_random_send(32);
        write_random_send(33);
        write_word(34, make_op(OP_BAD));
        write_random_send(35);
        write_word(36, make_op(OP_END));
        end_writes();
        run_program(32);

        // start near the top and run through the wrap, skipping the word before start
        apply_reset();
        write_random_send(8'hfb);
        write_random_send(8'hfc);
        write_word(8'hfd, make_delay(2));
        write_random_send(8'hfe);
        write_random_send(8'hff);
        write_random_send(8'h00);
        write_word(8'h01, make_op(OP_END));
        end_writes();
        run_program(8'hfc);
        apply_reset();                      // strobe drops only here

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/lcd_pkg.sv
rtl/lcd_ram.sv
rtl/lcd_nybble_sender.sv
rtl/lcd_byte_sender.sv
rtl/lcd_sequencer.sv
rtl/lcd_top.sv
tb/tb_clock.sv
tb/tb_lcd_top.sv
